// ==== src/tcb_pkg.sv ====
// TCB subsystem shared definitions
// bus widths, vector types, response delays and the SRAM state encoding

package tcb_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  // address width, one SRAM word per address
  localparam int unsigned TCB_ADR_W = 8;
  // data width for both write and read data
  localparam int unsigned TCB_DAT_W = 32;

  // request address
  typedef logic [TCB_ADR_W-1:0] tcb_adr_t;
  // write data and read data
  typedef logic [TCB_DAT_W-1:0] tcb_dat_t;

  ////////////////////
  // memory and delays
  ////////////////////

  // number of SRAM words, covers the whole address range
  localparam int unsigned TCB_MEM_DEPTH = 2**TCB_ADR_W;

  // cycles from a transfer at the SRAM to its read data
  localparam int unsigned TCB_DLY_SRAM = 1;

  // cycles from a transfer at the top ports to the response
  // the request slice adds exactly one cycle on top of the SRAM
  localparam int unsigned TCB_DLY_TOP = TCB_DLY_SRAM + 1;

  ////////////////////
  // SRAM state machine
  ////////////////////

  // IDLE     no transfer in the previous cycle
  // ACCESS   read transfer in the previous cycle, rdt holds its word
  // RECOVER  write transfer in the previous cycle, array settling
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ACCESS  = 2'd1,
    RECOVER = 2'd2
  } sram_state_t;

endpackage

// ==== src/tcb_if.sv ====
// TCB point to point bus
// valid/ready request handshake, response data at a fixed delay

`timescale 1ns/1ns

interface tcb_if (
  input logic sub,
  input logic rst_n
);

  ////////////////////
  // handshake
  ////////////////////

  // request valid, driven by the manager
  logic vld;
  // request ready, driven by the subordinate
  logic rdy;

  ////////////////////
  // request
  ////////////////////

  // write enable, low for a read
  logic wen;
  // word address
  tcb_pkg::tcb_adr_t adr;
  // write data, ignored on reads
  tcb_pkg::tcb_dat_t wdt;

  ////////////////////
  // response
  ////////////////////

  // read data, valid at the bus delay after a read transfer
  // no strobe on this bus, the manager counts cycles itself
  tcb_pkg::tcb_dat_t rdt;

  // manager side, issues requests
  modport man (
    input  sub,
    input  rst_n,
    output vld,
    output wen,
    output adr,
    output wdt,
    input  rdy,
    input  rdt
  );

  // subordinate side, serves requests
  modport sbr (
    input  sub,
    input  rst_n,
    input  vld,
    input  wen,
    input  adr,
    input  wdt,
    output rdy,
    output rdt
  );

endinterface

// ==== src/tcb_man_port.sv ====
// TCB manager port adapter
// maps plain request ports onto a TCB manager and strobes read responses
// after the fixed top level delay

`timescale 1ns/1ns

module tcb_man_port (
  // request from the outside
  input  logic              req_vld,
  input  logic              req_wen,
  input  tcb_pkg::tcb_adr_t req_adr,
  input  tcb_pkg::tcb_dat_t req_wdt,
  output logic              req_rdy,
  // response to the outside
  output logic              rsp_vld,
  output tcb_pkg::tcb_dat_t rsp_rdt,
  // bus towards the request slice
  tcb_if.man                bus
);

  ////////////////////
  // request path
  ////////////////////

  // fields go straight onto the bus
  assign bus.vld = req_vld;
  assign bus.wen = req_wen;
  assign bus.adr = req_adr;
  assign bus.wdt = req_wdt;

  // ready comes straight back, the slice never stalls when empty
  assign req_rdy = bus.rdy;

  ////////////////////
  // response tracking
  ////////////////////

  // one flag per cycle of response delay
  logic [tcb_pkg::TCB_DLY_TOP-1:0] rd_pipe;
  // read accepted at this edge
  logic                            rd_xfer;

  assign rd_xfer = req_vld & req_rdy & ~req_wen;

  // shift in a flag for every read transfer
  // writes push a zero, so they never raise rsp_vld
  always_ff @(posedge bus.sub) begin
    if (!bus.rst_n) begin
      rd_pipe <= '0;
    end else begin
      rd_pipe <= {rd_pipe[tcb_pkg::TCB_DLY_TOP-2:0], rd_xfer};
    end
  end

  // last stage lines up with the SRAM read data arriving through the slice
  // rsp_vld and rsp_rdt are sampled together, TCB_DLY_TOP edges after the transfer
  assign rsp_vld = rd_pipe[tcb_pkg::TCB_DLY_TOP-1];

  // data passes through, only meaningful while rsp_vld is high
  assign rsp_rdt = bus.rdt;

  ////////////////////
  // checks
  ////////////////////

  // a stalled request keeps its fields until it is taken
  property p_req_stable;
    @(posedge bus.sub) disable iff (!bus.rst_n)
      (req_vld && !req_rdy) |=>
        (req_vld && $stable(req_wen) && $stable(req_adr) && $stable(req_wdt));
  endproperty

  a_req_stable: assert property (p_req_stable)
    else $error("request changed while stalled");

endmodule

// ==== src/tcb_register_request.sv ====
// TCB request path register slice
// breaks the request timing path with one register stage, no bubbles,
// read data passes back unregistered

`timescale 1ns/1ns

module tcb_register_request (
  // from the manager side
  tcb_if.sbr bus_sbr,
  // towards the subordinate side
  tcb_if.man bus_man
);

  ////////////////////
  // handshake
  ////////////////////

  // stage valid, reloaded whenever the upstream is ready
  always_ff @(posedge bus_sbr.sub) begin
    if (!bus_sbr.rst_n) begin
      bus_man.vld <= 1'b0;
    end else if (bus_sbr.rdy) begin
      bus_man.vld <= bus_sbr.vld;
    end
  end

  // take a new request when the stage drains this cycle or is empty
  // checking valid here avoids a bubble after every stall
  assign bus_sbr.rdy = bus_man.rdy | ~bus_man.vld;

  ////////////////////
  // request
  ////////////////////

  // payload, same enable as the valid so a held request stays intact
  always_ff @(posedge bus_sbr.sub) begin
    if (bus_sbr.rdy) begin
      bus_man.wen <= bus_sbr.wen;
      bus_man.adr <= bus_sbr.adr;
      bus_man.wdt <= bus_sbr.wdt;
    end
  end

  ////////////////////
  // response
  ////////////////////

  // no delay on the way back, total delay grows by one only
  assign bus_sbr.rdt = bus_man.rdt;

  ////////////////////
  // checks
  ////////////////////

  // a registered request is held until the subordinate takes it
  property p_hold_until_xfer;
    @(posedge bus_sbr.sub) disable iff (!bus_sbr.rst_n)
      (bus_man.vld && !bus_man.rdy) |=>
        (bus_man.vld && $stable(bus_man.adr) && $stable(bus_man.wen) &&
         $stable(bus_man.wdt));
  endproperty

  a_hold_until_xfer: assert property (p_hold_until_xfer)
    else $error("slice dropped a request before transfer");

endmodule

// ==== src/tcb_sram_sub.sv ====
// TCB single port SRAM subordinate
// registered read data one cycle after the transfer, one recovery cycle
// after every write during which a second write is held off

`timescale 1ns/1ns

module tcb_sram_sub (
  // request from the slice
  tcb_if.sbr bus
);

  ////////////////////
  // storage
  ////////////////////

  // word array, left uninitialized
  tcb_pkg::tcb_dat_t mem [tcb_pkg::TCB_MEM_DEPTH];

  // current and next state
  tcb_pkg::sram_state_t state_q;
  tcb_pkg::sram_state_t state_d;

  // transfer decode
  logic xfer;
  logic wr_xfer;
  logic rd_xfer;

  assign xfer    = bus.vld & bus.rdy;
  assign wr_xfer = xfer & bus.wen;
  assign rd_xfer = xfer & ~bus.wen;

  ////////////////////
  // state machine
  ////////////////////

  // state follows the kind of transfer in the cycle just ended
  always_comb begin
    state_d = tcb_pkg::IDLE;
    if (wr_xfer) begin
      state_d = tcb_pkg::RECOVER;
    end else if (rd_xfer) begin
      state_d = tcb_pkg::ACCESS;
    end
  end

  always_ff @(posedge bus.sub) begin
    if (!bus.rst_n) begin
      state_q <= tcb_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // recovery blocks only the next write
  // reads keep their fixed latency through the slice
  assign bus.rdy = (state_q != tcb_pkg::RECOVER) | ~bus.wen;

  ////////////////////
  // array access
  ////////////////////

  // write port
  always_ff @(posedge bus.sub) begin
    if (wr_xfer) begin
      mem[bus.adr] <= bus.wdt;
    end
  end

  // read port, rdt keeps the last word read until the next read
  always_ff @(posedge bus.sub) begin
    if (rd_xfer) begin
      bus.rdt <= mem[bus.adr];
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // never two writes on back to back edges
  property p_write_recovery;
    @(posedge bus.sub) disable iff (!bus.rst_n)
      wr_xfer |=> !wr_xfer;
  endproperty

  a_write_recovery: assert property (p_write_recovery)
    else $error("write accepted during recovery");

endmodule

// ==== src/tcb_top.sv ====
// TCB subsystem top level
// manager port adapter, request slice and SRAM on two internal buses,
// plain request and response ports outside

`timescale 1ns/1ns

module tcb_top (
  input  logic              sub,
  input  logic              rst_n,
  // request
  input  logic              req_vld,
  input  logic              req_wen,
  input  tcb_pkg::tcb_adr_t req_adr,
  input  tcb_pkg::tcb_dat_t req_wdt,
  output logic              req_rdy,
  // response
  output logic              rsp_vld,
  output tcb_pkg::tcb_dat_t rsp_rdt
);

  ////////////////////
  // buses
  ////////////////////

  // adapter to slice
  tcb_if bus_in (
    .sub   (sub),
    .rst_n (rst_n)
  );

  // slice to SRAM
  tcb_if bus_out (
    .sub   (sub),
    .rst_n (rst_n)
  );

  ////////////////////
  // blocks
  ////////////////////

  // input side
  tcb_man_port i_man_port (
    .req_vld (req_vld),
    .req_wen (req_wen),
    .req_adr (req_adr),
    .req_wdt (req_wdt),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt),
    .bus     (bus_in.man)
  );

  // request slice, adds one cycle
  tcb_register_request i_register_request (
    .bus_sbr (bus_in.sbr),
    .bus_man (bus_out.man)
  );

  // output side
  tcb_sram_sub i_sram_sub (
    .bus (bus_out.sbr)
  );

endmodule

// ==== sim/tcb_tb.sv ====
// testbench for the TCB subsystem
// seeded random requests against a reference memory model, checks read
// data and the fixed response delay at the top level ports

`timescale 1ns/1ns

module tcb_tb;

  ////////////////////
  // constants
  ////////////////////

  // half of the 100 ns clock period
  localparam int HALF_PERIOD = 50;
  // edges from a read transfer at the ports to its response
  localparam int RSP_DLY = 2;
  // request counts per test
  localparam int N_WRB   = 16;
  localparam int N_B2B   = 32;
  localparam int N_STALL = 48;
  localparam int N_RAND  = 300;
  // four cycles per transfer, slack for reset, idle and drain cycles
  localparam int CYCLE_LIMIT = (2 * N_WRB + N_B2B + N_STALL + N_RAND) * 4 + 100;

  // DUT ports
  logic              sub;
  logic              rst_n;
  logic              req_vld;
  logic              req_wen;
  tcb_pkg::tcb_adr_t req_adr;
  tcb_pkg::tcb_dat_t req_wdt;
  logic              req_rdy;
  logic              rsp_vld;
  tcb_pkg::tcb_dat_t rsp_rdt;

  // reference memory and written flags
  tcb_pkg::tcb_dat_t model_mem [tcb_pkg::TCB_MEM_DEPTH];
  logic              model_ok  [tcb_pkg::TCB_MEM_DEPTH];
  // expected responses, due cycle and word
  int                exp_due [$];
  tcb_pkg::tcb_dat_t exp_dat [$];
  // addresses that hold a known word
  tcb_pkg::tcb_adr_t adr_list [$];

  // bookkeeping
  integer      seed;
  int          cycle;
  int          err_cnt;
  int          xfer_cnt;
  int          rsp_cnt;
  int          err_base;
  int          xfer_base;
  int          rsp_base;
  int          sent_cnt;
  int          read_cnt;
  int          stall_cnt;
  int          tests_run;
  int          tests_bad;
  string       cur_test;

  tcb_top i_dut (
    .sub     (sub),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_wen (req_wen),
    .req_adr (req_adr),
    .req_wdt (req_wdt),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt)
  );

  always #HALF_PERIOD sub = ~sub;

  ////////////////////
  // monitor
  ////////////////////

  // response slot of this edge, a strobe anywhere else is an error
  task automatic check_response();
    if (exp_due.size() > 0 && exp_due[0] == cycle) begin
      if (rsp_vld !== 1'b1) begin
        $display("ERROR %s: rsp_vld at cycle %0d expected 1 actual %b", cur_test, cycle, rsp_vld);
        err_cnt++;
      end else begin
        rsp_cnt++;
        if (rsp_rdt !== exp_dat[0]) begin
          $display("ERROR %s: rsp_rdt expected %h actual %h", cur_test, exp_dat[0], rsp_rdt);
          err_cnt++;
        end
      end
      exp_due.delete(0);
      exp_dat.delete(0);
    end else if (rsp_vld !== 1'b0) begin
      $display("ERROR %s: rsp_vld at cycle %0d expected 0 actual %b", cur_test, cycle, rsp_vld);
      err_cnt++;
    end
  endtask

  // a transfer updates the model in bus order
  task automatic record_transfer();
    if (req_vld && req_rdy) begin
      xfer_cnt++;
      if (req_wen) begin
        model_mem[req_adr] = req_wdt;
        model_ok[req_adr]  = 1'b1;
      end else begin
        if (!model_ok[req_adr]) begin
          $display("%s: read of address %h before any write to it", cur_test, req_adr);
          err_cnt++;
        end
        exp_due.push_back(cycle + RSP_DLY);
        exp_dat.push_back(model_mem[req_adr]);
      end
    end
  endtask

  always @(posedge sub) begin
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles in test %s", cycle, cur_test);
      $display("tests failed");
      $finish;
    end else if (rst_n) begin
      check_response();
      record_transfer();
    end
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  // hold one request until it is taken, count stalled edges
  task automatic send_request(input logic wen, input tcb_pkg::tcb_adr_t adr,
                              input tcb_pkg::tcb_dat_t wdt);
    @(negedge sub);
    req_vld = 1'b1;
    req_wen = wen;
    req_adr = adr;
    req_wdt = wdt;
    sent_cnt++;
    if (!wen) begin
      read_cnt++;
    end
    @(posedge sub);
    while (!req_rdy) begin
      stall_cnt++;
      @(posedge sub);
    end
  endtask

  // valid low for n whole cycles
  task automatic idle(input int n);
    repeat (n) begin
      @(negedge sub);
      req_vld = 1'b0;
    end
  endtask

  // random address among those already written
  function automatic tcb_pkg::tcb_adr_t pick_adr();
    logic [31:0] rnd;
    int          idx;
    rnd = $random(seed);
    idx = rnd % adr_list.size();
    return adr_list[idx];
  endfunction

  task automatic start_test(input string name);
    cur_test  = name;
    err_base  = err_cnt;
    xfer_base = xfer_cnt;
    rsp_base  = rsp_cnt;
    sent_cnt  = 0;
    read_cnt  = 0;
    stall_cnt = 0;
  endtask

  // drain the responses, then compare the counts of the test
  task automatic finish_test();
    int errs;
    idle(1);
    while (exp_due.size() > 0) begin
      @(negedge sub);
    end
    repeat (2) @(negedge sub);
    if (xfer_cnt - xfer_base != sent_cnt) begin
      $display("ERROR %s: transfers expected %0d actual %0d", cur_test, sent_cnt,
               xfer_cnt - xfer_base);
      err_cnt++;
    end
    if (rsp_cnt - rsp_base != read_cnt) begin
      $display("ERROR %s: responses expected %0d actual %0d", cur_test, read_cnt,
               rsp_cnt - rsp_base);
      err_cnt++;
    end
    errs = err_cnt - err_base;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: passed", cur_test);
    end else begin
      $display("test %s: failed with %0d errors", cur_test, errs);
      tests_bad++;
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    logic [31:0]       rnd;
    tcb_pkg::tcb_adr_t adr;
    int                writes;
    sub     = 1'b0;
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req_wen = 1'b0;
    req_adr = '0;
    req_wdt = '0;
    seed    = 13;
    cycle   = 0;
    err_cnt = 0;
    xfer_cnt  = 0;
    rsp_cnt   = 0;
    tests_run = 0;
    tests_bad = 0;
    cur_test  = "reset";
    for (int i = 0; i < tcb_pkg::TCB_MEM_DEPTH; i++) begin
      model_ok[i] = 1'b0;
    end
    repeat (3) @(posedge sub);
    @(negedge sub);
    rst_n = 1'b1;

    // ready and quiet with no requests
    start_test("reset_idle");
    repeat (8) begin
      @(negedge sub);
      if (req_rdy !== 1'b1) begin
        $display("ERROR %s: req_rdy expected 1 actual %b", cur_test, req_rdy);
        err_cnt++;
      end
    end
    finish_test();

    // upper nibble from the loop keeps the addresses distinct
    start_test("write_read_back");
    for (int i = 0; i < N_WRB; i++) begin
      rnd = $random(seed);
      adr = {i[3:0], rnd[3:0]};
      adr_list.push_back(adr);
      send_request(1'b1, adr, $random(seed));
    end
    for (int i = 0; i < N_WRB; i++) begin
      send_request(1'b0, adr_list[i], $random(seed));
    end
    finish_test();

    // reads never see the write recovery
    start_test("back_to_back_reads");
    for (int i = 0; i < N_B2B; i++) begin
      send_request(1'b0, pick_adr(), '0);
    end
    if (stall_cnt != 0) begin
      $display("ERROR %s: stalled edges expected 0 actual %0d", cur_test, stall_cnt);
      err_cnt++;
    end
    finish_test();

    // two writes out of three, so writes meet back to back
    start_test("write_recovery_stall");
    writes = 0;
    for (int i = 0; i < N_STALL; i++) begin
      if (i % 3 == 0) begin
        send_request(1'b0, pick_adr(), '0);
      end else begin
        writes++;
        send_request(1'b1, pick_adr(), $random(seed));
      end
    end
    if (stall_cnt == 0 || stall_cnt > writes) begin
      $display("%s: %0d stalled edges for %0d writes, expected between 1 and %0d",
               cur_test, stall_cnt, writes, writes);
      err_cnt++;
    end
    finish_test();

    // random kind, data and gaps in valid
    start_test("random_mix");
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      if (rnd[3:2] == 2'b00) begin
        idle(1);
      end
      send_request(rnd[0], pick_adr(), $random(seed));
    end
    finish_test();

    $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - tests_bad,
             tests_bad);
    if (err_cnt == 0 && tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
src/tcb_pkg.sv
src/tcb_if.sv
src/tcb_man_port.sv
src/tcb_register_request.sv
src/tcb_sram_sub.sv
src/tcb_top.sv
sim/tcb_tb.sv

// ==== Makefile ====
# Verilator build and run for the TCB subsystem
# the binary is rebuilt only when a source or the file list changes

VERILATOR ?= verilator
TOP       ?= tcb_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= all tests passed
FAIL_MSG  ?= tests failed

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, a missing pass line also counts as failure
run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
